//--- Bender.yml
package:
  name: sb_core

export_include_dirs:
  - hw

sources:
  - hw/sb_pkg.sv
  - hw/inuse_scoreboard.sv
  - hw/reg_file.sv
  - hw/instr_queue.sv
  - hw/issue_unit.sv
  - hw/alu_pipe.sv
  - hw/sb_core_top.sv
  - target: test
    files:
      - tb/sb_core_assertions.sv
      - tb/sb_core_tb.sv

//--- compile.f
+incdir+hw
hw/sb_pkg.sv
hw/inuse_scoreboard.sv
hw/reg_file.sv
hw/instr_queue.sv
hw/issue_unit.sv
hw/alu_pipe.sv
hw/sb_core_top.sv
tb/sb_core_assertions.sv
tb/sb_core_tb.sv

//--- hw/alu_pipe.sv
////////////////////////////////////////////////////////////////////////////
// alu and writeback pipeline
// result computed at issue, then carried through a fixed-depth shift line
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "sb_cfg.svh"

module alu_pipe (
    input  logic                clk,
    input  logic                rst,
    input  logic                issue,
    input  sb_pkg::instr_t      instr,
    input  logic [`SB_XLEN-1:0] rs1_data,
    input  logic [`SB_XLEN-1:0] rs2_data,
    output sb_pkg::wb_t         wb
);
    import sb_pkg::*;

    localparam int depth = `SB_ALU_DEPTH;

    logic [`SB_XLEN-1:0] imm_ext;
    logic [`SB_XLEN-1:0] result;

    // valid tags, reset so the line drains cleanly
    logic [depth-1:0]    vld_q;
    // payload, no reset
    reg_addr_t           rd_q [depth];
    logic [`SB_XLEN-1:0] data_q [depth];

    // sign extension of the 12 bit immediate
    assign imm_ext = {{(`SB_XLEN - `SB_IMM_W){instr.imm[`SB_IMM_W-1]}}, instr.imm};

    always_comb begin
        case (instr.op)
            op_add:  result = rs1_data + rs2_data;
            op_sub:  result = rs1_data - rs2_data;
            op_xor:  result = rs1_data ^ rs2_data;
            default: result = rs1_data + imm_ext;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // shift line, one stage per cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= issue;
            for (int i = 1; i < depth; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_q[0]   <= instr.rd;
        data_q[0] <= result;
        for (int i = 1; i < depth; i++) begin
            rd_q[i]   <= rd_q[i-1];
            data_q[i] <= data_q[i-1];
        end
    end

    // last stage is the writeback
    assign wb.valid = vld_q[depth-1];
    assign wb.rd    = rd_q[depth-1];
    assign wb.data  = data_q[depth-1];

endmodule

//--- hw/instr_queue.sv
////////////////////////////////////////////////////////////////////////////
// instruction queue
// circular buffer with full and empty levels
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "sb_cfg.svh"

module instr_queue (
    input  logic           clk,
    input  logic           rst,
    input  logic           push,
    input  sb_pkg::instr_t din,
    input  logic           pop,
    output sb_pkg::instr_t head,
    output logic           empty,
    output logic           full
);
    import sb_pkg::*;

    localparam int depth = `SB_QUEUE_DEPTH;
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    instr_t           mem [depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    // a push while full is dropped
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // payload storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == cnt_w'(depth));

endmodule

//--- hw/inuse_scoreboard.sv
////////////////////////////////////////////////////////////////////////////
// register in-use scoreboard
// two toggle banks, issue and completion ports, three lookup ports
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "sb_cfg.svh"

module inuse_scoreboard (
    input  logic              clk,
    input  logic              rst,
    input  logic              clr,
    input  sb_pkg::reg_addr_t clear_addr,
    input  logic              issue,
    input  sb_pkg::reg_addr_t issue_rd,
    input  logic              completed,
    input  sb_pkg::reg_addr_t wb_rd,
    input  sb_pkg::reg_addr_t rs1_addr,
    input  sb_pkg::reg_addr_t rs2_addr,
    input  sb_pkg::reg_addr_t rd_addr,
    output logic              rs1_inuse,
    output logic              rs2_inuse,
    output logic              rd_inuse
);
    import sb_pkg::*;

    // one bit per register in each bank
    // issue toggles bank_issue, completion copies it into bank_comp
    logic [`SB_NUM_REGS-1:0] bank_issue;
    logic [`SB_NUM_REGS-1:0] bank_comp;

    // completion side address, the clear walk takes it over
    reg_addr_t comp_addr;
    logic      collision;
    logic      issue_we;
    logic      comp_we;

    assign comp_addr = clr ? clear_addr : wb_rd;

    // same register issuing and completing this cycle
    assign collision = completed & (wb_rd == issue_rd);

    // banks hold while reset is applied
    assign issue_we = ~rst & issue;
    assign comp_we  = ~rst & (completed | clr);

    ////////////////////////////////////////////////////////////////////////////
    // bank updates

    // issue wins a collision
    // toggling against the completing value keeps the banks different
    always_ff @(posedge clk) begin
        if (issue_we) begin
            bank_issue[issue_rd] <= collision ? ~bank_issue[wb_rd] : ~bank_comp[issue_rd];
        end else if (~rst && clr) begin
            // walk zeroes the issue side too
            bank_issue[clear_addr] <= 1'b0;
        end
    end

    // completion makes the pair equal again
    always_ff @(posedge clk) begin
        if (comp_we) begin
            bank_comp[comp_addr] <= clr ? 1'b0 : bank_issue[comp_addr];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // lookups

    // in use while the two banks disagree
    assign rs1_inuse = bank_issue[rs1_addr] ^ bank_comp[rs1_addr];
    assign rs2_inuse = bank_issue[rs2_addr] ^ bank_comp[rs2_addr];
    assign rd_inuse  = bank_issue[rd_addr] ^ bank_comp[rd_addr];

endmodule

//--- hw/issue_unit.sv
////////////////////////////////////////////////////////////////////////////
// issue control
// post-reset clear walk, hazard check and in-order issue of the head
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "sb_cfg.svh"

module issue_unit (
    input  logic              clk,
    input  logic              rst,
    input  sb_pkg::instr_t    head,
    input  logic              empty,
    output logic              pop,
    input  logic              rs1_inuse,
    input  logic              rs2_inuse,
    input  logic              rd_inuse,
    output logic              clr,
    output sb_pkg::reg_addr_t clear_addr,
    output logic              issue,
    output logic              ready
);
    import sb_pkg::*;

    // last register visited by the walk
    localparam reg_addr_t last_addr = reg_addr_t'(`SB_NUM_REGS - 1);

    logic uses_rs2;
    logic hazard;

    ////////////////////////////////////////////////////////////////////////////
    // clear walk

    // clr high for one pass over every register
    // ready rises as the walk ends and stays up
    always_ff @(posedge clk) begin
        if (rst) begin
            clr        <= 1'b1;
            clear_addr <= '0;
            ready      <= 1'b0;
        end else if (clr) begin
            clear_addr <= clear_addr + 1'b1;
            if (clear_addr == last_addr) begin
                clr   <= 1'b0;
                ready <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // hazard check

    // addi takes the immediate, rs2 field is ignored
    assign uses_rs2 = (head.op != op_addi);

    // raw on either source, waw on the destination
    assign hazard = rs1_inuse | (uses_rs2 & rs2_inuse) | rd_inuse;

    ////////////////////////////////////////////////////////////////////////////
    // issue

    // first cycle with a clean head goes out
    assign issue = ready & ~empty & ~hazard;

    // head leaves the queue as it issues
    assign pop = issue;

endmodule

//--- hw/reg_file.sv
////////////////////////////////////////////////////////////////////////////
// integer register file
// two combinational reads, one write, zero fill during the clear walk
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "sb_cfg.svh"

module reg_file (
    input  logic                clk,
    input  sb_pkg::reg_addr_t   rs1_addr,
    input  sb_pkg::reg_addr_t   rs2_addr,
    output logic [`SB_XLEN-1:0] rs1_data,
    output logic [`SB_XLEN-1:0] rs2_data,
    input  logic                we,
    input  sb_pkg::reg_addr_t   waddr,
    input  logic [`SB_XLEN-1:0] wdata,
    input  logic                clr,
    input  sb_pkg::reg_addr_t   clear_addr
);

    // storage, contents set by the clear walk
    logic [`SB_XLEN-1:0] regs [`SB_NUM_REGS];

    ////////////////////////////////////////////////////////////////////////////
    // write port

    // clear walk takes the port over
    // x0 may be written, reads mask it
    always_ff @(posedge clk) begin
        if (clr) begin
            regs[clear_addr] <= '0;
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read ports

    // no bypass, a write shows up the cycle after
    always_comb begin
        rs1_data = regs[rs1_addr];
        rs2_data = regs[rs2_addr];
        // x0 is hardwired
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end
        if (rs2_addr == '0) begin
            rs2_data = '0;
        end
    end

endmodule

//--- hw/sb_cfg.svh
////////////////////////////////////////////////////////////////////////////
// size macros for the issue and writeback slice
// data width, register file, queue and alu pipeline depth
////////////////////////////////////////////////////////////////////////////

`ifndef SB_CFG_SVH
`define SB_CFG_SVH

// integer data width
`define SB_XLEN 32

// architectural registers, x0 included
`define SB_NUM_REGS 32

// register address width follows the register count
`define SB_REG_AW $clog2(`SB_NUM_REGS)

// immediate field width of an instruction
`define SB_IMM_W 12

// instruction queue entries
`define SB_QUEUE_DEPTH 4

// alu stages between issue and writeback, at least 1
`define SB_ALU_DEPTH 3

`endif

//--- hw/sb_core_top.sv
////////////////////////////////////////////////////////////////////////////
// core slice top level
// queue, issue control, scoreboard, register file and alu pipeline
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "sb_cfg.svh"

module sb_core_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           instr_push,
    input  sb_pkg::instr_t instr,
    output logic           queue_full,
    output logic           ready,
    output sb_pkg::wb_t    wb
);
    import sb_pkg::*;

    // queue head and handshake levels
    instr_t              head;
    logic                empty;
    logic                pop;

    // issue control
    logic                clr;
    reg_addr_t           clear_addr;
    logic                issue;

    // scoreboard lookups for the head
    logic                rs1_inuse;
    logic                rs2_inuse;
    logic                rd_inuse;

    // operands
    logic [`SB_XLEN-1:0] rs1_data;
    logic [`SB_XLEN-1:0] rs2_data;

    ////////////////////////////////////////////////////////////////////////////
    // front end

    instr_queue queue_i (
        .clk   (clk),
        .rst   (rst),
        .push  (instr_push),
        .din   (instr),
        .pop   (pop),
        .head  (head),
        .empty (empty),
        .full  (queue_full)
    );

    issue_unit issue_i (
        .clk        (clk),
        .rst        (rst),
        .head       (head),
        .empty      (empty),
        .pop        (pop),
        .rs1_inuse  (rs1_inuse),
        .rs2_inuse  (rs2_inuse),
        .rd_inuse   (rd_inuse),
        .clr        (clr),
        .clear_addr (clear_addr),
        .issue      (issue),
        .ready      (ready)
    );

    // completion port fed from the writeback
    inuse_scoreboard sb_i (
        .clk        (clk),
        .rst        (rst),
        .clr        (clr),
        .clear_addr (clear_addr),
        .issue      (issue),
        .issue_rd   (head.rd),
        .completed  (wb.valid),
        .wb_rd      (wb.rd),
        .rs1_addr   (head.rs1),
        .rs2_addr   (head.rs2),
        .rd_addr    (head.rd),
        .rs1_inuse  (rs1_inuse),
        .rs2_inuse  (rs2_inuse),
        .rd_inuse   (rd_inuse)
    );

    ////////////////////////////////////////////////////////////////////////////
    // execute and writeback

    reg_file rf_i (
        .clk        (clk),
        .rs1_addr   (head.rs1),
        .rs2_addr   (head.rs2),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .we         (wb.valid),
        .waddr      (wb.rd),
        .wdata      (wb.data),
        .clr        (clr),
        .clear_addr (clear_addr)
    );

    alu_pipe alu_i (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .instr    (head),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

endmodule

//--- hw/sb_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared types of the core slice
// opcode, register address, instruction and writeback records
////////////////////////////////////////////////////////////////////////////

`include "sb_cfg.svh"

package sb_pkg;

    // register index
    typedef logic [`SB_REG_AW-1:0] reg_addr_t;

    // alu operations
    // addi takes the sign-extended immediate in place of rs2
    typedef enum logic [1:0] {
        op_add  = 2'b00,
        op_sub  = 2'b01,
        op_xor  = 2'b10,
        op_addi = 2'b11
    } alu_op_e;

    // instruction as it enters the queue
    typedef struct packed {
        alu_op_e                op;
        reg_addr_t              rd;
        reg_addr_t              rs1;
        reg_addr_t              rs2;
        logic [`SB_IMM_W-1:0]   imm;
    } instr_t;

    // result leaving the alu pipeline
    // valid marks the writeback cycle
    typedef struct packed {
        logic                   valid;
        reg_addr_t              rd;
        logic [`SB_XLEN-1:0]    data;
    } wb_t;

endpackage

//--- tb/sb_core_assertions.sv
////////////////////////////////////////////////////////////////////////////
// protocol and timing assertions, bound to the core slice top level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "sb_cfg.svh"

module sb_core_assertions (
    input logic        clk,
    input logic        rst,
    input logic        instr_push,
    input logic        queue_full,
    input logic        ready,
    input logic        clr,
    input logic        issue,
    input sb_pkg::wb_t wb
);

    // failed assertions so far, read by the testbench
    int unsigned fail_count = 0;

    // nothing retires before the walk is over
    wb_quiet_before_ready: assert property (@(posedge clk) disable iff (rst)
        !ready |-> !wb.valid)
        else begin
            fail_count++;
            $error("writeback while ready is low");
        end

    // source must respect the full level
    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        instr_push |-> !queue_full)
        else begin
            fail_count++;
            $error("push while the queue is full");
        end

    // ready is sticky
    ready_holds: assert property (@(posedge clk) disable iff (rst)
        ready |=> ready)
        else begin
            fail_count++;
            $error("ready fell after rising");
        end

    no_issue_in_walk: assert property (@(posedge clk) disable iff (rst)
        !(issue && clr))
        else begin
            fail_count++;
            $error("issue during the clear walk");
        end

    // fixed pipeline latency
    issue_to_wb: assert property (@(posedge clk) disable iff (rst)
        issue |-> ##(`SB_ALU_DEPTH) wb.valid)
        else begin
            fail_count++;
            $error("writeback missing after issue");
        end

endmodule

bind sb_core_top sb_core_assertions assertions_i (
    .clk        (clk),
    .rst        (rst),
    .instr_push (instr_push),
    .queue_full (queue_full),
    .ready      (ready),
    .clr        (clr),
    .issue      (issue),
    .wb         (wb)
);

//--- tb/sb_core_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the core slice
// clock, reset, lfsr stimulus, reference model, compare and watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "sb_cfg.svh"

module sb_core_tb;
    import sb_pkg::*;

    localparam int num_random     = 200;
    localparam int directed_count = 21;
    localparam int total_instr    = directed_count + num_random;
    // worst case is a full dependency chain plus the walk
    localparam longint watchdog_ns =
        longint'(`SB_NUM_REGS + 20 + total_instr * (`SB_ALU_DEPTH + 2)) * 100 * 2;
    // a full queue plus the pipeline, each one waiting on the one before
    localparam int drain_limit =
        (`SB_QUEUE_DEPTH + `SB_ALU_DEPTH + 1) * (`SB_ALU_DEPTH + 2);

    logic   clk;
    logic   rst;
    logic   instr_push;
    instr_t instr;
    logic   queue_full;
    logic   ready;
    wb_t    wb;

    // reference state
    logic [`SB_XLEN-1:0] model_regs [`SB_NUM_REGS];
    wb_t                 exp_q [$];
    wb_t                 exp_wb;
    logic [15:0]         lfsr;
    string               test_name;
    int                  cycles;

    sb_core_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .instr_push (instr_push),
        .instr      (instr),
        .queue_full (queue_full),
        .ready      (ready),
        .wb         (wb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // checking helpers

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: %s expected %0h actual %0h", what, expected, actual);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    // galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic instr_t make_instr(input alu_op_e op, input reg_addr_t rd,
                                          input reg_addr_t rs1, input reg_addr_t rs2,
                                          input logic [11:0] imm);
        instr_t x;
        x.op  = op;
        x.rd  = rd;
        x.rs1 = rs1;
        x.rs2 = rs2;
        x.imm = imm;
        return x;
    endfunction

    // small register window so hazards and stalls are frequent
    function automatic instr_t random_instr();
        instr_t x;
        x.op  = alu_op_e'(take_bits(2));
        x.rd  = reg_addr_t'(take_bits(3));
        x.rs1 = reg_addr_t'(take_bits(3));
        x.rs2 = reg_addr_t'(take_bits(3));
        x.imm = 12'(take_bits(12));
        return x;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // reference model

    // program order update, x0 result shows on wb but is not kept
    function automatic wb_t ref_apply(input instr_t x);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] r;
        wb_t         w;
        a   = model_regs[x.rs1];
        b   = model_regs[x.rs2];
        imm = {{20{x.imm[11]}}, x.imm};
        case (x.op)
            op_add:  r = a + b;
            op_sub:  r = a - b;
            op_xor:  r = a ^ b;
            default: r = a + imm;
        endcase
        if (x.rd != '0) begin
            model_regs[x.rd] = r;
        end
        w.valid = 1'b1;
        w.rd    = x.rd;
        w.data  = r;
        return w;
    endfunction

    // full sampled mid-cycle, one push per two cycles keeps it current
    task automatic push_instr(input instr_t x);
        @(negedge clk);
        while (queue_full) begin
            @(negedge clk);
        end
        @(posedge clk);
        instr_push <= 1'b1;
        instr      <= x;
        exp_q.push_back(ref_apply(x));
        @(posedge clk);
        instr_push <= 1'b0;
    endtask

    // bounded wait for every expected writeback
    task automatic drain_writebacks();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < drain_limit) begin
            @(negedge clk);
            waited++;
        end
        check_value({test_name, " expected queue"}, 0, exp_q.size());
        // room for a stray writeback to show up
        repeat (2 * `SB_ALU_DEPTH) @(negedge clk);
    endtask

    // every writeback against the head of the expected queue
    always @(negedge clk) begin
        if (wb.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                fail_run("writeback seen with no instruction outstanding");
            end else begin
                exp_wb = exp_q.pop_front();
                check_value({test_name, " rd"}, 32'(exp_wb.rd), 32'(wb.rd));
                check_value({test_name, " data"}, exp_wb.data, wb.data);
            end
        end
    end

    // bound checker counts its assertion failures
    always @(dut_i.assertions_i.fail_count) begin
        if (dut_i.assertions_i.fail_count != 0) begin
            fail_run("an assertion in the bound checker failed");
        end
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: the run hung, writebacks stopped arriving");
        $display("Done: errors found");
        $fatal(1);
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        rst        = 1'b1;
        instr_push = 1'b0;
        instr      = '0;
        lfsr       = 16'd71;
        test_name  = "reset";
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // clear walk, ready after one pass over the registers
        // the queue fills meanwhile since nothing can issue
        test_name = "clear_walk";
        cycles = 0;
        fork
            begin
                @(negedge clk);
                while (ready !== 1'b1 && cycles < 4 * `SB_NUM_REGS) begin
                    cycles++;
                    if (wb.valid === 1'b1) begin
                        fail_run("writeback seen during the clear walk");
                    end
                    @(negedge clk);
                end
            end
            begin
                push_instr(make_instr(op_add, 5'd3, 5'd1, 5'd2, 12'h000));
                push_instr(make_instr(op_addi, 5'd4, 5'd0, 5'd0, 12'h0a5));
                push_instr(make_instr(op_xor, 5'd5, 5'd3, 5'd4, 12'h000));
                @(negedge clk);
                check_value({test_name, " queue_full"}, 0, queue_full);
                push_instr(make_instr(op_sub, 5'd6, 5'd0, 5'd4, 12'h000));
                @(negedge clk);
                check_value({test_name, " queue_full"}, 1, queue_full);
            end
        join
        check_value("clear_walk ready delay", `SB_NUM_REGS, cycles);
        drain_writebacks();

        // independent immediates, both signs
        test_name = "independent";
        push_instr(make_instr(op_addi, 5'd1, 5'd0, 5'd0, 12'h005));
        push_instr(make_instr(op_addi, 5'd2, 5'd0, 5'd0, 12'hfff));
        push_instr(make_instr(op_addi, 5'd3, 5'd0, 5'd0, 12'h7ff));
        push_instr(make_instr(op_addi, 5'd4, 5'd0, 5'd0, 12'h800));
        push_instr(make_instr(op_addi, 5'd5, 5'd0, 5'd0, 12'h123));
        drain_writebacks();

        // raw chain, each one needs the one before
        test_name = "raw_chain";
        push_instr(make_instr(op_add, 5'd6, 5'd1, 5'd2, 12'h000));
        push_instr(make_instr(op_sub, 5'd7, 5'd6, 5'd3, 12'h000));
        push_instr(make_instr(op_xor, 5'd8, 5'd7, 5'd6, 12'h000));
        push_instr(make_instr(op_add, 5'd9, 5'd8, 5'd8, 12'h000));
        push_instr(make_instr(op_sub, 5'd10, 5'd0, 5'd9, 12'h000));
        push_instr(make_instr(op_addi, 5'd10, 5'd10, 5'd0, 12'h001));
        drain_writebacks();

        // waw on x11, then x0 writes that must not stick
        test_name = "waw_x0";
        push_instr(make_instr(op_addi, 5'd11, 5'd0, 5'd0, 12'h001));
        push_instr(make_instr(op_addi, 5'd11, 5'd0, 5'd0, 12'h002));
        push_instr(make_instr(op_addi, 5'd11, 5'd0, 5'd0, 12'h003));
        push_instr(make_instr(op_add, 5'd12, 5'd11, 5'd0, 12'h000));
        push_instr(make_instr(op_addi, 5'd0, 5'd0, 5'd0, 12'h055));
        push_instr(make_instr(op_add, 5'd13, 5'd0, 5'd0, 12'h000));
        drain_writebacks();

        // random stream, queue fills behind stalled heads
        test_name = "random_stream";
        for (int n = 0; n < num_random; n++) begin
            push_instr(random_instr());
        end
        drain_writebacks();

        $display("Done: no errors");
        $finish;
    end

endmodule
